/* bench/i2c_vectors.txt */
# op bit_ctrl word_addr data, address and data in hex
# W writes the data byte, R reads the address and expects the data byte
W 0 0012 a5
R 0 0012 a5
W 0 00ff 3c
R 0 00ff 3c
W 1 1234 5e
W 1 2234 c7
R 1 1234 5e
R 1 2234 c7
W 1 ff00 01
R 1 ff00 01
W 0 0012 e8
R 0 0012 e8
W 1 8001 7f
R 1 8001 7f

/* src.f */
hw/i2c_pkg.sv
hw/i2c_phase_seq.sv
hw/i2c_bit_engine.sv
hw/i2c_master_top.sv
bench/i2c_mem_slave.sv
bench/tb_i2c_master.sv

/* run_sim.sh */
#!/bin/bash
# build the testbench with Verilator, run it and scan the log for the fail message
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i2c_master \
    -f src.f \
    -o sim_i2c_master

./obj_dir/sim_i2c_master | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

/* bench/tb_i2c_master.sv */
// testbench top with clock, reset, vector replay, random write/read pairs and the report
`timescale 1ns/100ps

module tb_i2c_master;

    localparam logic [6:0] dev_addr    = 7'b1010000;
    localparam int         timeout_cyc = 400;
    localparam int         rand_pairs  = 12;
    localparam string      vec_file    = "bench/i2c_vectors.txt";

    logic        i2c_driv_clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        bit_ctrl;
    logic        i2c_rh_wl;
    logic [15:0] i2c_addr;
    logic [7:0]  i2c_data_w;
    wire  [7:0]  i2c_data_r;
    wire         i2c_done;
    wire         scl;
    wire         sda;
    wire  [7:0]  dev_first;
    wire  [7:0]  dev_rep;
    wire  [15:0] dev_cnt;
    logic [7:0]  shadow [0:65535];      // expected slave memory
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          seed;
    bit          timed_out;

    pullup (sda);

    i2c_master_top UUT (
        .i2c_driv_clk (i2c_driv_clk),
        .rst_n        (rst_n),
        .i2c_exec     (i2c_exec),
        .bit_ctrl     (bit_ctrl),
        .i2c_rh_wl    (i2c_rh_wl),
        .i2c_addr     (i2c_addr),
        .i2c_data_w   (i2c_data_w),
        .i2c_data_r   (i2c_data_r),
        .i2c_done     (i2c_done),
        .scl          (scl),
        .sda          (sda)
    );

    i2c_mem_slave #(.dev_addr(dev_addr)) mem_slave (
        .i2c_driv_clk (i2c_driv_clk),
        .rst_n        (rst_n),
        .bit_ctrl     (bit_ctrl),
        .scl          (scl),
        .sda          (sda),
        .dev_first    (dev_first),
        .dev_rep      (dev_rep),
        .dev_cnt      (dev_cnt)
    );

    initial i2c_driv_clk = 1'b0;
    always #20 i2c_driv_clk = ~i2c_driv_clk;

    // exec sample, start + device byte, low address byte, stop, then the optional parts
    function automatic int expected_cycles(input logic rd, input logic wide);
        int n;
        n = 1 + 40 + 36 + 17;
        if (wide) begin
            n = n + 36;
        end
        n = rd ? n + 40 + 36 : n + 36;     // repeated start and read byte, or data byte
        return n;
    endfunction

    function automatic logic [15:0] mem_index(input logic wide, input logic [15:0] addr);
        return wide ? addr : {8'h00, addr[7:0]};
    endfunction

    task automatic report_mismatch(input string name, input int got, input int expv);
        errors++;
        $display("[ERROR] t=%0d ns  %s  got %0h  expected %0h", $time, name, got, expv);
    endtask

    task automatic close_test(input string what, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0d  %s  ok", tests_run, what);
        end else begin
            tests_failed++;
            $display("test %0d  %s  failed with %0d error(s)", tests_run, what, errs);
        end
    endtask

    task automatic run_op(input logic rd, input logic wide, input logic [15:0] addr,
                          input logic [7:0] data);
        int          n;
        int          err_start;
        bit          seen;
        logic [15:0] cnt_start;
        logic [15:0] idx;
        string       what;

        err_start = errors;
        cnt_start = dev_cnt;
        idx       = mem_index(wide, addr);
        what = $sformatf("%s a%0d %04h %02h", rd ? "R" : "W", wide ? 16 : 8, addr, data);
        @(posedge i2c_driv_clk);
        #2;
        i2c_exec   = 1'b1;
        bit_ctrl   = wide;
        i2c_rh_wl  = rd;
        i2c_addr   = addr;
        i2c_data_w = rd ? 8'h00 : data;
        @(posedge i2c_driv_clk);
        #2;
        i2c_exec = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < timeout_cyc) begin
            @(negedge i2c_driv_clk);
            n++;
            seen = i2c_done;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("%s  no i2c_done within %0d cycles, run stopped", what, timeout_cyc);
        end else begin
            if (n != expected_cycles(rd, wide)) begin
                report_mismatch("exec-to-done cycles", n, expected_cycles(rd, wide));
            end
            if (rd && i2c_data_r !== data) begin
                report_mismatch("i2c_data_r", i2c_data_r, data);
            end
            // stored byte shows the order of the address bytes
            if (!rd && mem_slave.mem[idx] !== data) begin
                report_mismatch("slave memory byte", mem_slave.mem[idx], data);
            end
            @(negedge i2c_driv_clk);
            if (i2c_done !== 1'b0) begin
                errors++;
                $display("i2c_done stayed high for a second cycle in %s", what);
            end
            if (dev_first !== {dev_addr, 1'b0}) begin
                report_mismatch("device address byte", dev_first, {dev_addr, 1'b0});
            end
            if (rd && dev_rep !== {dev_addr, 1'b1}) begin
                report_mismatch("repeated-start address byte", dev_rep, {dev_addr, 1'b1});
            end
            if (16'(dev_cnt - cnt_start) != (rd ? 16'd2 : 16'd1)) begin
                report_mismatch("address bytes seen", 16'(dev_cnt - cnt_start), rd ? 2 : 1);
            end
        end
        if (!rd) begin
            shadow[idx] = data;
        end
        close_test(what, errors - err_start);
    endtask

    initial begin : main_seq
        int          fd;
        int          code;
        int          wide_v;
        int          err_start;
        string       line;
        logic [7:0]  op_c;
        logic [15:0] addr_v;
        logic [7:0]  data_v;
        logic [15:0] r_addr;
        logic [7:0]  r_data;
        logic        r_wide;

        rst_n        = 1'b0;
        i2c_exec     = 1'b0;
        bit_ctrl     = 1'b0;
        i2c_rh_wl    = 1'b0;
        i2c_addr     = '0;
        i2c_data_w   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        seed         = 37;

        repeat (8) @(posedge i2c_driv_clk);
        #2;
        rst_n = 1'b1;
        @(negedge i2c_driv_clk);
        err_start = errors;
        if (scl !== 1'b1) begin
            report_mismatch("scl", scl, 1);
        end
        if (sda !== 1'b1) begin
            report_mismatch("sda", sda, 1);
        end
        if (i2c_done !== 1'b0) begin
            report_mismatch("i2c_done", i2c_done, 0);
        end
        close_test("reset state", errors - err_start);

        // --------------------
        // directed vectors
        // --------------------
        fd = $fopen(vec_file, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file %s", vec_file);
        end else begin
            while (!timed_out && !$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %d %h %h", op_c, wide_v, addr_v, data_v);
                    if (code != 4 || (op_c != "W" && op_c != "R")) begin
                        errors++;
                        $display("vector line not understood: %s", line);
                    end else begin
                        run_op(op_c == "R", wide_v != 0, addr_v, data_v);
                    end
                end
            end
            $fclose(fd);
        end

        // --------------------
        // random pairs
        // --------------------
        for (int k = 0; k < rand_pairs && !timed_out; k++) begin
            r_addr = 16'($random(seed));
            r_data = 8'($random(seed));
            r_wide = 1'($random(seed));
            run_op(1'b0, r_wide, r_addr, r_data);
            if (!timed_out) begin
                run_op(1'b1, r_wide, r_addr, shadow[mem_index(r_wide, r_addr)]);
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* bench/i2c_mem_slave.sv */
// behavioral i2c memory slave with a 16-bit address space and a log of device address bytes
`timescale 1ns/100ps

module i2c_mem_slave #(
    parameter logic [6:0] dev_addr = 7'b1010000
) (
    input  logic        i2c_driv_clk,
    input  logic        rst_n,
    input  logic        bit_ctrl,           // 1 = two address bytes expected
    input  logic        scl,
    inout  wire         sda,
    output logic [7:0]  dev_first,          // device byte after a start
    output logic [7:0]  dev_rep,            // device byte after a repeated start
    output logic [15:0] dev_cnt
);

    typedef enum logic [2:0] {st_idle, st_dev, st_waddr, st_wdata, st_tx, st_wait} slave_state_t;

    logic [7:0]   mem [0:65535];
    slave_state_t state;
    logic         scl_q;
    logic         sda_q;
    logic [3:0]   bit_cnt;                  // 8 = ack slot, 9 = ack clocked
    logic [7:0]   rx_byte;
    logic [7:0]   byte_in;
    logic [7:0]   tx_byte;
    logic [15:0]  ptr;
    logic         hi_done;
    logic         ack_pend;
    logic         repeated;
    logic         drive_low;

    assign sda     = drive_low ? 1'b0 : 1'bz;
    assign byte_in = {rx_byte[6:0], sda};

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;  // fill depends on both address bytes
        end
    end

    // bus sampled on the falling clock, away from the master's edges
    always @(negedge i2c_driv_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bit_cnt   <= '0;
            ack_pend  <= 1'b0;
            repeated  <= 1'b0;
            drive_low <= 1'b0;
            dev_cnt   <= '0;
            dev_first <= '0;
            dev_rep   <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) begin
                state    <= st_dev;             // start or repeated start
                bit_cnt  <= '0;
                repeated <= (state != st_idle);
            end else if (scl_q && scl && !sda_q && sda) begin
                state <= st_idle;               // stop
            end else if (state != st_idle) begin
                if (!scl_q && scl) begin
                    if (bit_cnt < 4'd8) begin
                        rx_byte <= byte_in;
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7) begin
                            case (state)
                                st_dev: begin
                                    dev_cnt <= dev_cnt + 16'd1;
                                    if (repeated) begin
                                        dev_rep <= byte_in;
                                    end else begin
                                        dev_first <= byte_in;
                                    end
                                    ack_pend <= (byte_in[7:1] == dev_addr);
                                    if (byte_in[7:1] != dev_addr) begin
                                        state <= st_wait;
                                    end else if (byte_in[0]) begin
                                        state   <= st_tx;
                                        tx_byte <= mem[ptr];
                                    end else begin
                                        state   <= st_waddr;
                                        hi_done <= 1'b0;
                                    end
                                end
                                st_waddr: begin
                                    ack_pend <= 1'b1;
                                    if (bit_ctrl && !hi_done) begin
                                        ptr[15:8] <= byte_in;
                                        hi_done   <= 1'b1;
                                    end else begin
                                        ptr   <= {bit_ctrl ? ptr[15:8] : 8'h00, byte_in};
                                        state <= st_wdata;
                                    end
                                end
                                st_wdata: begin
                                    ack_pend <= 1'b1;
                                    mem[ptr] <= byte_in;
                                    ptr      <= ptr + 16'd1;
                                end
                                default: ;
                            endcase
                        end
                    end else begin
                        bit_cnt <= 4'd9;
                        if (state == st_tx && sda) begin
                            state <= st_wait;   // master nack ends the read
                        end
                    end
                end else if (scl_q && !scl) begin
                    drive_low <= 1'b0;          // let go right after scl falls
                    if (bit_cnt == 4'd9) begin
                        bit_cnt  <= '0;
                        ack_pend <= 1'b0;
                    end
                end else if (!scl_q && !scl) begin
                    if (bit_cnt == 4'd8 && ack_pend) begin
                        drive_low <= 1'b1;
                    end else if (state == st_tx && bit_cnt < 4'd8) begin
                        drive_low <= !tx_byte[3'd7 - bit_cnt[2:0]];
                    end
                end
            end
        end
    end

endmodule

/* hw/i2c_master_top.sv */
// top level joining the phase sequencer, the bit engine and the open-drain sda
`timescale 1ns/100ps

module i2c_master_top (
    input  logic                         i2c_driv_clk,
    input  logic                         rst_n,
    input  logic                         i2c_exec,
    input  logic                         bit_ctrl,
    input  logic                         i2c_rh_wl,
    input  logic [i2c_pkg::WADDR_W-1:0]  i2c_addr,
    input  logic [i2c_pkg::BYTE_W-1:0]   i2c_data_w,
    output logic [i2c_pkg::BYTE_W-1:0]   i2c_data_r,
    output logic                         i2c_done,
    output logic                         scl,
    inout  wire                          sda
);

    import i2c_pkg::*;

    i2c_phase_t         phase;
    logic [BYTE_W-1:0]  tx_byte;
    logic               phase_done;
    logic               sda_oe;
    logic               sda_o;
    logic               sda_i;

    assign sda   = sda_oe ? sda_o : 1'bz;  // released when slave owns the line
    assign sda_i = sda;

    i2c_phase_seq u_seq (
        .i2c_driv_clk (i2c_driv_clk),
        .rst_n        (rst_n),
        .i2c_exec     (i2c_exec),
        .bit_ctrl     (bit_ctrl),
        .i2c_rh_wl    (i2c_rh_wl),
        .i2c_addr     (i2c_addr),
        .i2c_data_w   (i2c_data_w),
        .phase_done   (phase_done),
        .phase        (phase),
        .tx_byte      (tx_byte)
    );

    i2c_bit_engine u_engine (
        .i2c_driv_clk (i2c_driv_clk),
        .rst_n        (rst_n),
        .phase        (phase),
        .tx_byte      (tx_byte),
        .sda_i        (sda_i),
        .phase_done   (phase_done),
        .scl          (scl),
        .sda_oe       (sda_oe),
        .sda_o        (sda_o),
        .i2c_data_r   (i2c_data_r),
        .i2c_done     (i2c_done)
    );

endmodule

/* hw/i2c_bit_engine.sv */
// bit engine timing scl and sda inside each phase, shifting bytes out and in
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic                        i2c_driv_clk,
    input  logic                        rst_n,
    input  i2c_pkg::i2c_phase_t         phase,
    input  logic [i2c_pkg::BYTE_W-1:0]  tx_byte,
    input  logic                        sda_i,
    output logic                        phase_done,
    output logic                        scl,
    output logic                        sda_oe,
    output logic                        sda_o,
    output logic [i2c_pkg::BYTE_W-1:0]  i2c_data_r,
    output logic                        i2c_done
);

    import i2c_pkg::*;

    logic [CNT_W-1:0]   cnt;            // cycle inside the phase
    logic [CNT_W-1:0]   len;
    logic [CNT_W-1:0]   rel;            // cycle relative to first data bit
    logic               has_prefix;
    logic               is_last;
    logic [2:0]         bit_idx;
    logic [BYTE_W-1:0]  rx_shift;

    // --------------------
    // phase decode
    // --------------------
    always_comb begin
        has_prefix = (phase == PH_SLADDR) || (phase == PH_ADDR_RD);
        case (phase)
            PH_SLADDR, PH_ADDR_RD: len = LEN_START_BYTE;
            PH_STOP:               len = LEN_STOP;
            default:               len = LEN_BYTE;
        endcase
        rel     = has_prefix ? cnt - 7'(CYC_PER_BIT) : cnt;
        is_last = (cnt == len - 7'd1);
        bit_idx = 3'd7 - rel[4:2];      // msb goes first
    end

    // --------------------
    // scl / sda sequencing
    // --------------------
    always_ff @(posedge i2c_driv_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            scl        <= 1'b1;
            sda_o      <= 1'b1;
            sda_oe     <= 1'b1;
            phase_done <= 1'b0;
            i2c_done   <= 1'b0;
        end else begin
            phase_done <= 1'b0;
            i2c_done   <= 1'b0;
            if (phase == PH_IDLE) begin
                cnt    <= '0;
                scl    <= 1'b1;     // bus parked high
                sda_o  <= 1'b1;
                sda_oe <= 1'b1;
            end else begin
                cnt <= is_last ? '0 : cnt + 7'd1;
                if (cnt == len - 7'd2) begin
                    phase_done <= 1'b1;     // sequencer steps at the wrap
                end
                if (phase == PH_STOP) begin
                    case (cnt)
                        7'd0: begin
                            sda_oe <= 1'b1;
                            sda_o  <= 1'b0;
                        end
                        7'd1:    scl   <= 1'b1;
                        7'd3:    sda_o <= 1'b1;  // stop condition
                        default: ;
                    endcase
                    if (is_last) begin
                        i2c_done <= 1'b1;
                    end
                end else if (has_prefix && cnt < 7'(CYC_PER_BIT)) begin
                    case (cnt[1:0])
                        2'd0: begin
                            sda_oe <= 1'b1;
                            sda_o  <= 1'b1;
                        end
                        2'd1:    scl   <= 1'b1;
                        2'd2:    sda_o <= 1'b0;  // (repeated) start
                        default: scl   <= 1'b0;
                    endcase
                end else if (rel < ACK_SLOT) begin
                    case (rel[1:0])
                        2'd0: begin
                            if (phase == PH_DATA_RD) begin
                                sda_oe <= 1'b0;  // slave drives the byte
                            end else begin
                                sda_oe <= 1'b1;
                                sda_o  <= tx_byte[bit_idx];
                            end
                        end
                        2'd1:    scl <= 1'b1;
                        2'd3:    scl <= 1'b0;
                        default: ;
                    endcase
                end else begin
                    case (rel[1:0])
                        2'd0: begin
                            // nack after the read byte, else let the slave answer
                            sda_oe <= (phase == PH_DATA_RD);
                            sda_o  <= 1'b1;
                        end
                        2'd1:    scl <= 1'b1;
                        2'd3:    scl <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // --------------------
    // receive path
    // --------------------
    always_ff @(posedge i2c_driv_clk) begin
        if (phase == PH_DATA_RD && rel < ACK_SLOT && rel[1:0] == 2'd1) begin
            rx_shift <= {rx_shift[BYTE_W-2:0], sda_i};  // taken as scl rises
        end
        if (phase == PH_DATA_RD && is_last) begin
            i2c_data_r <= rx_shift;
        end
    end

    a_scl_idle_high: assert property (
        @(posedge i2c_driv_clk) disable iff (!rst_n)
        (phase == PH_IDLE) |-> scl
    ) else $error("scl low while idle");

    a_done_single: assert property (
        @(posedge i2c_driv_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done
    ) else $error("i2c_done held for two cycles");

    // sda may only move under a high scl for start and stop
    a_sda_stable: assert property (
        @(posedge i2c_driv_clk) disable iff (!rst_n)
        (scl && $past(scl) && (sda_i != $past(sda_i))) |-> sda_oe
    ) else $error("sda changed while scl high and master released");

endmodule

/* hw/i2c_phase_seq.sv */
// phase sequencer holding the request and stepping through the bus phases
`timescale 1ns/100ps

module i2c_phase_seq (
    input  logic                         i2c_driv_clk,
    input  logic                         rst_n,
    input  logic                         i2c_exec,
    input  logic                         bit_ctrl,
    input  logic                         i2c_rh_wl,
    input  logic [i2c_pkg::WADDR_W-1:0]  i2c_addr,
    input  logic [i2c_pkg::BYTE_W-1:0]   i2c_data_w,
    input  logic                         phase_done,
    output i2c_pkg::i2c_phase_t          phase,
    output logic [i2c_pkg::BYTE_W-1:0]   tx_byte
);

    import i2c_pkg::*;

    i2c_phase_t         phase_nxt;
    word_addr_u         addr_q;         // captured word address
    logic [BYTE_W-1:0]  wdata_q;        // captured write data
    logic               rd_q;           // 1 = read request
    logic               wide_q;         // 1 = two address bytes

    // --------------------
    // request capture
    // --------------------
    always_ff @(posedge i2c_driv_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q   <= 1'b0;
            wide_q <= 1'b0;
        end else if (phase == PH_IDLE && i2c_exec) begin
            rd_q   <= i2c_rh_wl;
            wide_q <= bit_ctrl;
        end
    end

    always_ff @(posedge i2c_driv_clk) begin
        if (phase == PH_IDLE && i2c_exec) begin
            addr_q.word <= i2c_addr;
            wdata_q     <= i2c_data_w;
        end
    end

    // --------------------
    // phase stepping
    // --------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: begin
                if (i2c_exec) begin
                    phase_nxt = PH_SLADDR;
                end
            end
            PH_SLADDR: begin
                if (phase_done) begin
                    phase_nxt = wide_q ? PH_ADDR16 : PH_ADDR8;
                end
            end
            PH_ADDR16: begin
                if (phase_done) begin
                    phase_nxt = PH_ADDR8;
                end
            end
            PH_ADDR8: begin
                if (phase_done) begin
                    phase_nxt = rd_q ? PH_ADDR_RD : PH_DATA_WR;  // dummy write ends here
                end
            end
            PH_DATA_WR: begin
                if (phase_done) begin
                    phase_nxt = PH_STOP;
                end
            end
            PH_ADDR_RD: begin
                if (phase_done) begin
                    phase_nxt = PH_DATA_RD;
                end
            end
            PH_DATA_RD: begin
                if (phase_done) begin
                    phase_nxt = PH_STOP;
                end
            end
            PH_STOP: begin
                if (phase_done) begin
                    phase_nxt = PH_IDLE;
                end
            end
            default: phase_nxt = PH_IDLE;   // recover from an illegal code
        endcase
    end

    always_ff @(posedge i2c_driv_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // byte handed to the engine for the current phase
    always_comb begin
        case (phase)
            PH_SLADDR:  tx_byte = {SLAVE_ADDR, I2C_WR};
            PH_ADDR_RD: tx_byte = {SLAVE_ADDR, I2C_RD};
            PH_ADDR16:  tx_byte = addr_q.bytes.hi_byte;
            PH_ADDR8:   tx_byte = addr_q.bytes.lo_byte;
            PH_DATA_WR: tx_byte = wdata_q;
            default:    tx_byte = '0;   // nothing shifted out
        endcase
    end

    a_phase_onehot: assert property (
        @(posedge i2c_driv_clk) disable iff (!rst_n)
        $onehot(phase)
    ) else $error("phase register lost its one-hot code");

endmodule

/* hw/i2c_pkg.sv */
// bus constants, one-hot phase codes, phase lengths and the word-address union
package i2c_pkg;

    // --------------------
    // bus constants
    // --------------------
    localparam logic [6:0] SLAVE_ADDR  = 7'b1010000;   // 7-bit device address
    localparam int         BYTE_W      = 8;
    localparam int         WADDR_W     = 16;
    localparam int         CYC_PER_BIT = 4;            // driver clocks per scl period
    localparam int         CNT_W       = 7;            // phase cycle counter width
    localparam logic       I2C_WR      = 1'b0;         // r/w bit after device address
    localparam logic       I2C_RD      = 1'b1;

    // --------------------
    // phase codes
    // --------------------
    typedef logic [7:0] i2c_phase_t;

    localparam i2c_phase_t PH_IDLE    = 8'b0000_0001;
    localparam i2c_phase_t PH_SLADDR  = 8'b0000_0010;  // start + device address, write
    localparam i2c_phase_t PH_ADDR16  = 8'b0000_0100;  // high word-address byte
    localparam i2c_phase_t PH_ADDR8   = 8'b0000_1000;  // low word-address byte
    localparam i2c_phase_t PH_DATA_WR = 8'b0001_0000;
    localparam i2c_phase_t PH_ADDR_RD = 8'b0010_0000;  // repeated start + address, read
    localparam i2c_phase_t PH_DATA_RD = 8'b0100_0000;
    localparam i2c_phase_t PH_STOP    = 8'b1000_0000;

    // --------------------
    // phase lengths in driver clocks
    // --------------------
    localparam logic [CNT_W-1:0] LEN_START_BYTE = 7'd40;  // prefix bit + 8 bits + ack
    localparam logic [CNT_W-1:0] LEN_BYTE       = 7'd36;  // 8 bits + ack
    localparam logic [CNT_W-1:0] LEN_STOP       = 7'd17;
    localparam logic [CNT_W-1:0] ACK_SLOT       = 7'(BYTE_W * CYC_PER_BIT);

    // word address, seen whole at capture and per byte when shifted out
    typedef union packed {
        logic [WADDR_W-1:0] word;
        struct packed {
            logic [BYTE_W-1:0] hi_byte;
            logic [BYTE_W-1:0] lo_byte;
        } bytes;
    } word_addr_u;

endpackage
